// File: project.f
logic/cache_geom_pkg.sv
logic/cache_ctrl_pkg.sv
logic/data_array.sv
logic/data_port_arbiter.sv
logic/store_buffer.sv
logic/tag_store.sv
logic/cache_main_ctrl.sv
logic/cache_top.sv
test/cache_assert.sv
test/cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@if grep -qx "CHECKS FAILED" $(LOG) || ! grep -qx "ALL CHECKS PASSED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/cache_tb.sv
// directed testbench for the data cache with a line bus memory model, run as the simulation top
`timescale 1ns/1ns
`default_nettype none

module cache_tb
  import cache_geom_pkg::*;
  import cache_ctrl_pkg::*;
();

  localparam int CLK_PERIOD  = 4;
  localparam int N_ACCESS    = 16;   // upper bound on accesses issued
  localparam int MISS_CYCLES = 24;   // worst case miss with both bus delays
  localparam int WATCHDOG_NS = (N_ACCESS * MISS_CYCLES + 20) * CLK_PERIOD;
  localparam logic [31:0] LFSR_POLY = 32'h80200003;

  typedef logic [ADDR_W-4:0] waddr_t;   // 64-bit word address

  logic               i_clk;
  logic               i_rst;
  logic               i_valid;
  op_t                i_op;
  tag_t               i_tag;
  index_t             i_index;
  offset_t            i_offset;
  strb_t              i_wstrb;
  word_t              i_wdata;
  logic               o_addr_ok;
  logic               o_data_ok;
  word_t              o_rdata;
  logic               o_rd_req;
  logic [ADDR_W-1:0]  o_rd_addr;
  logic               i_rd_rdy;
  logic               i_ret_valid;
  logic               i_ret_last;
  word_t              i_ret_data;
  logic               o_wr_req;
  logic [ADDR_W-1:0]  o_wr_addr;
  line_t              o_wr_data;
  logic               i_wr_rdy;

  int          errors;
  int          checks;
  logic [31:0] lfsr_q;

  // bus model state
  word_t             bus_mem [waddr_t];
  word_t             ref_mem [waddr_t];   // architectural memory
  logic              rd_pending;
  int                rd_delay;
  int                wr_delay;
  int                beat_idx;            // beat on the bus, -1 when none
  logic [ADDR_W-1:0] rd_line;
  int                rd_seen;
  int                wr_seen;
  logic              exp_wr;
  logic [ADDR_W-1:0] exp_wr_addr;
  logic [ADDR_W-1:0] exp_rd_addr;
  line_t             exp_wr_line;

  // shadow tag state
  tag_t sh_tag   [SETS][WAYS];
  logic sh_valid [SETS][WAYS];
  logic sh_dirty [SETS][WAYS];
  way_t sh_victim;

  cache_top DUT (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_op        (i_op),
    .i_tag       (i_tag),
    .i_index     (i_index),
    .i_offset    (i_offset),
    .i_wstrb     (i_wstrb),
    .i_wdata     (i_wdata),
    .o_addr_ok   (o_addr_ok),
    .o_data_ok   (o_data_ok),
    .o_rdata     (o_rdata),
    .o_rd_req    (o_rd_req),
    .o_rd_addr   (o_rd_addr),
    .i_rd_rdy    (i_rd_rdy),
    .i_ret_valid (i_ret_valid),
    .i_ret_last  (i_ret_last),
    .i_ret_data  (i_ret_data),
    .o_wr_req    (o_wr_req),
    .o_wr_addr   (o_wr_addr),
    .o_wr_data   (o_wr_data),
    .i_wr_rdy    (i_wr_rdy)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // helpers

  // galois lfsr, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ LFSR_POLY : lfsr_q >> 1;
    end
    return v;
  endfunction

  function automatic word_t fill_word(input waddr_t a);
    return {a, ~a, 6'h2a};   // unwritten memory pattern
  endfunction

  function automatic word_t bus_word(input waddr_t a);
    if (bus_mem.exists(a)) return bus_mem[a];
    return fill_word(a);
  endfunction

  function automatic word_t ref_word(input waddr_t a);
    if (ref_mem.exists(a)) return ref_mem[a];
    return fill_word(a);
  endfunction

  function automatic line_t ref_line(input logic [ADDR_W-1:0] a);
    line_t l;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      l[w*WORD_W +: WORD_W] = ref_word({a[ADDR_W-1:OFFSET_W], word_sel_t'(w)});
    end
    return l;
  endfunction

  function automatic word_t merge_bytes(input word_t old, input word_t nw, input strb_t s);
    word_t r;
    r = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (s[b]) r[b*8 +: 8] = nw[b*8 +: 8];
    end
    return r;
  endfunction

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_line(input line_t got, input line_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------
  // bus memory model, driven after the edge and sampled before the next one
  task automatic bus_drive();
    i_wr_rdy    = wr_delay == 0;
    i_rd_rdy    = rd_pending && rd_delay == 0;
    i_ret_valid = beat_idx >= 0;
    i_ret_last  = beat_idx == WORDS_PER_LINE - 1;
    i_ret_data  = '0;
    if (beat_idx >= 0) begin
      i_ret_data = bus_word({rd_line[ADDR_W-1:OFFSET_W], word_sel_t'(beat_idx)});
    end
  endtask

  task automatic bus_sample();
    if (o_wr_req) begin
      wr_seen++;
      if (exp_wr) begin
        check_addr(o_wr_addr, exp_wr_addr, "victim address");
        check_line(o_wr_data, exp_wr_line, "victim line");
      end
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        bus_mem[{o_wr_addr[ADDR_W-1:OFFSET_W], word_sel_t'(w)}] = o_wr_data[w*WORD_W +: WORD_W];
      end
    end
    if (wr_delay > 0) wr_delay--;
    if (beat_idx >= 0) begin
      beat_idx = (beat_idx == WORDS_PER_LINE - 1) ? -1 : beat_idx + 1;
    end else if (rd_pending) begin
      if (i_rd_rdy) begin
        rd_pending = 1'b0;
        beat_idx   = 0;      // beats start next cycle
      end else begin
        rd_delay--;
      end
    end else if (o_rd_req) begin
      rd_seen++;
      check_addr(o_rd_addr, exp_rd_addr, "refill address");
      rd_line    = o_rd_addr;
      rd_pending = 1'b1;
      rd_delay   = int'(rand_bits(2));
    end
  endtask

  // one request through the pipeline port, checked against the shadow state
  task automatic access(input op_t op, input tag_t tag, input index_t idx,
                        input word_sel_t wsel, input strb_t strb, input word_t wdata);
    waddr_t waddr;
    int     hit_way;
    way_t   vic;
    word_t  exp_word;
    logic   exp_hit;
    logic   accepted;
    logic   accept_now;
    logic   done;
    int     cyc;
    int     ok_cyc;
    int     n_ok;
    waddr   = {tag, idx, wsel};
    hit_way = -1;
    for (int w = 0; w < WAYS; w++) begin
      if (sh_valid[idx][w] && sh_tag[idx][w] == tag) hit_way = w;
    end
    exp_hit     = hit_way >= 0;
    vic         = sh_victim;
    exp_wr      = 1'b0;
    exp_rd_addr = {tag, idx, {OFFSET_W{1'b0}}};
    if (!exp_hit && sh_valid[idx][vic] && sh_dirty[idx][vic]) begin
      exp_wr      = 1'b1;
      exp_wr_addr = {sh_tag[idx][vic], idx, {OFFSET_W{1'b0}}};
      exp_wr_line = ref_line(exp_wr_addr);
    end
    if (op == OP_WRITE) ref_mem[waddr] = merge_bytes(ref_word(waddr), wdata, strb);
    exp_word = ref_word(waddr);
    if (exp_hit) begin
      if (op == OP_WRITE) sh_dirty[idx][hit_way] = 1'b1;
    end else begin
      sh_tag[idx][vic]   = tag;
      sh_valid[idx][vic] = 1'b1;
      sh_dirty[idx][vic] = op == OP_WRITE;   // store miss lands dirty
      sh_victim          = ~sh_victim;
    end

    rd_seen  = 0;
    wr_seen  = 0;
    wr_delay = int'(rand_bits(2));
    i_valid  = 1'b1;
    i_op     = op;
    i_tag    = tag;
    i_index  = idx;
    i_offset = {wsel, 3'b000};
    i_wstrb  = strb;
    i_wdata  = wdata;
    bus_drive();
    accepted = 1'b0;
    done     = 1'b0;
    cyc      = 0;
    ok_cyc   = 0;
    n_ok     = 0;
    while (!done) begin
      accept_now = 1'b0;
      #2;
      if (accepted) begin
        cyc++;
        if (o_data_ok) begin
          n_ok++;
          ok_cyc = cyc;
          if (op == OP_READ) begin
            check_word(o_rdata, exp_word, "load data");
            if (!exp_hit) check_bit(beat_idx == int'(wsel), 1'b1, "load miss on its beat");
          end
        end
        done = n_ok > 0 && o_addr_ok;
      end else begin
        accept_now = o_addr_ok;
      end
      bus_sample();
      @(posedge i_clk);
      #1;
      if (accept_now) begin
        accepted = 1'b1;
        i_valid  = 1'b0;
      end
      bus_drive();
    end
    check_bit(n_ok == 1, 1'b1, "single data_ok pulse");
    if (exp_hit || op == OP_WRITE) check_bit(ok_cyc == 1, 1'b1, "data_ok one cycle late");
    check_bit(rd_seen == 1, !exp_hit, "line read request");
    check_bit(wr_seen == 1, exp_wr, "victim write-back");
  endtask

  // --------------------------------------------------
  // directed tests
  task automatic test_reset();
    #2;
    check_bit(o_rd_req, 1'b0, "read request after reset");
    check_bit(o_wr_req, 1'b0, "write request after reset");
    check_bit(o_data_ok, 1'b0, "data_ok after reset");
    check_bit(o_addr_ok, 1'b1, "addr_ok after reset");
    @(posedge i_clk);
    #1;
  endtask

  task automatic test_load_miss();
    access(OP_READ, 21'h00123, 6'd5, 2'd2, '0, '0);
  endtask

  task automatic test_load_hit();
    access(OP_READ, 21'h00123, 6'd5, 2'd2, '0, '0);
    access(OP_READ, 21'h00123, 6'd5, 2'd1, '0, '0);
  endtask

  task automatic test_store_merge();
    access(OP_WRITE, 21'h00123, 6'd5, 2'd2, 8'h0f, rand_bits(64));   // hit
    access(OP_READ, 21'h00123, 6'd5, 2'd2, '0, '0);
    access(OP_WRITE, 21'h00456, 6'd9, 2'd3, 8'hf0, rand_bits(64));   // miss
    access(OP_READ, 21'h00456, 6'd9, 2'd3, '0, '0);
  endtask

  task automatic test_evict();
    access(OP_READ, 21'h000a1, 6'd12, 2'd0, '0, '0);
    access(OP_READ, 21'h000b2, 6'd12, 2'd1, '0, '0);    // set now full
    access(OP_WRITE, 21'h000a1, 6'd12, 2'd0, 8'h3c, rand_bits(64));
    access(OP_READ, 21'h000c3, 6'd12, 2'd2, '0, '0);    // dirty victim
    access(OP_READ, 21'h000d4, 6'd12, 2'd3, '0, '0);    // clean victim
    access(OP_READ, 21'h000a1, 6'd12, 2'd0, '0, '0);    // written back bytes return
    access(OP_READ, 21'h000e5, 6'd9, 2'd0, '0, '0);     // store-miss line goes out
    access(OP_READ, 21'h00456, 6'd9, 2'd3, '0, '0);
  endtask

  initial begin
    errors      = 0;
    checks      = 0;
    lfsr_q      = 32'hf1e9;
    i_rst       = 1'b1;
    i_valid     = 1'b0;
    i_op        = OP_READ;
    i_tag       = '0;
    i_index     = '0;
    i_offset    = '0;
    i_wstrb     = '0;
    i_wdata     = '0;
    i_rd_rdy    = 1'b0;
    i_ret_valid = 1'b0;
    i_ret_last  = 1'b0;
    i_ret_data  = '0;
    i_wr_rdy    = 1'b0;
    rd_pending  = 1'b0;
    rd_delay    = 0;
    wr_delay    = 0;
    beat_idx    = -1;
    rd_line     = '0;
    exp_wr      = 1'b0;
    sh_victim   = 1'b0;
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < WAYS; w++) begin
        sh_tag[s][w]   = '0;
        sh_valid[s][w] = 1'b0;
        sh_dirty[s][w] = 1'b0;
      end
    end
    repeat (2) @(posedge i_clk);
    #1;
    i_rst = 1'b0;

    test_reset();
    test_load_miss();
    test_load_hit();
    test_store_merge();
    test_evict();

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/cache_assert.sv
// protocol assertions for the cache top level, attached to cache_top by bind
`timescale 1ns/1ns
`default_nettype none

module cache_assert
  import cache_ctrl_pkg::*;
(
  input wire      i_clk,
  input wire      i_rst,
  input wire      i_valid,
  input wire op_t i_op,
  input wire      o_addr_ok,
  input wire      o_rd_req,
  input wire      o_wr_req
);

  // line read and victim write never share a cycle
  a_no_dual_req: assert property (
    @(posedge i_clk) disable iff (i_rst) !(o_rd_req && o_wr_req)
  ) else $error("read and write requests high together");

  a_wr_req_pulse: assert property (
    @(posedge i_clk) disable iff (i_rst) o_wr_req |=> !o_wr_req
  ) else $error("write request held for two cycles");   // must be a one-cycle pulse

  a_store_blocks: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (i_valid && o_addr_ok && i_op == OP_WRITE) |=> !o_addr_ok
  ) else $error("request port open in the cycle after a store");

endmodule

bind cache_top cache_assert u_cache_assert (
  .i_clk     (i_clk),
  .i_rst     (i_rst),
  .i_valid   (i_valid),
  .i_op      (i_op),
  .o_addr_ok (o_addr_ok),
  .o_rd_req  (o_rd_req),
  .o_wr_req  (o_wr_req)
);

`default_nettype wire

// File: logic/cache_top.sv
// two-way write-back data cache top level, pipeline port on one side and line bus on the other
`timescale 1ns/1ns
`default_nettype none

module cache_top
  import cache_geom_pkg::*;
  import cache_ctrl_pkg::*;
(
  input  wire                i_clk,
  input  wire                i_rst,
  // pipeline side
  input  wire                i_valid,
  input  wire op_t           i_op,
  input  wire tag_t          i_tag,
  input  wire index_t        i_index,
  input  wire offset_t       i_offset,
  input  wire strb_t         i_wstrb,
  input  wire word_t         i_wdata,
  output logic               o_addr_ok,
  output logic               o_data_ok,
  output word_t              o_rdata,
  // bus side
  output logic               o_rd_req,
  output logic [ADDR_W-1:0]  o_rd_addr,
  input  wire                i_rd_rdy,
  input  wire                i_ret_valid,
  input  wire                i_ret_last,
  input  wire word_t         i_ret_data,
  output logic               o_wr_req,
  output logic [ADDR_W-1:0]  o_wr_addr,
  output line_t              o_wr_data,
  input  wire                i_wr_rdy
);

  index_t    lookup_index;
  logic      fill_en;
  way_t      fill_way;
  tag_t      fill_tag;
  logic      fill_dirty;
  way_vec_t  hit_vec;
  logic      victim_dirty;
  tag_t      victim_tag;

  logic      sb_load;
  way_vec_t  sb_way_vec;
  index_t    sb_index;
  word_sel_t sb_wsel;
  strb_t     sb_strb;
  word_t     sb_data;

  logic      sb_req;
  way_t      sb_way;
  index_t    sb_req_index;
  word_sel_t sb_req_wsel;
  strb_t     sb_req_strb;
  word_t     sb_req_data;
  logic      sb_set_dirty;

  logic      mc_rd_en;
  logic      mc_wr_en;
  way_t      mc_way;
  word_sel_t mc_wsel;
  strb_t     mc_strb;
  word_t     mc_data;
  logic      mc_gnt;

  logic      arr_en;
  way_vec_t  arr_we;
  index_t    arr_index;
  line_t     arr_mask;
  line_t     arr_wdata;
  line_t     line_rd [WAYS];

  cache_main_ctrl u_main_ctrl (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_valid          (i_valid),
    .i_op             (i_op),
    .i_tag            (i_tag),
    .i_index          (i_index),
    .i_offset         (i_offset),
    .i_wstrb          (i_wstrb),
    .i_wdata          (i_wdata),
    .o_addr_ok        (o_addr_ok),
    .o_data_ok        (o_data_ok),
    .o_rdata          (o_rdata),
    .o_rd_req         (o_rd_req),
    .o_rd_addr        (o_rd_addr),
    .i_rd_rdy         (i_rd_rdy),
    .i_ret_valid      (i_ret_valid),
    .i_ret_last       (i_ret_last),
    .i_ret_data       (i_ret_data),
    .o_wr_req         (o_wr_req),
    .o_wr_addr        (o_wr_addr),
    .o_wr_data        (o_wr_data),
    .i_wr_rdy         (i_wr_rdy),
    .o_lookup_index   (lookup_index),
    .o_fill_en        (fill_en),
    .o_fill_way       (fill_way),
    .o_fill_tag       (fill_tag),
    .o_fill_dirty     (fill_dirty),
    .i_hit_vec        (hit_vec),
    .i_victim_dirty   (victim_dirty),
    .i_victim_tag     (victim_tag),
    .o_sb_load        (sb_load),
    .o_sb_way_vec     (sb_way_vec),
    .o_sb_index       (sb_index),
    .o_sb_wsel        (sb_wsel),
    .o_sb_strb        (sb_strb),
    .o_sb_data        (sb_data),
    .o_mc_rd_en       (mc_rd_en),
    .o_mc_wr_en       (mc_wr_en),
    .o_mc_way         (mc_way),
    .o_mc_wsel        (mc_wsel),
    .o_mc_strb        (mc_strb),
    .o_mc_data        (mc_data),
    .i_mc_gnt         (mc_gnt),
    .i_line_rd        (line_rd)
  );

  tag_store u_tag_store (
    .i_clk                (i_clk),
    .i_rst                (i_rst),
    .i_index              (lookup_index),
    .i_tag                (fill_tag),       // request tag
    .i_victim             (fill_way),
    .o_hit_vec            (hit_vec),
    .o_victim_valid_dirty (victim_dirty),
    .i_fill_en            (fill_en),
    .i_fill_way           (fill_way),
    .i_fill_tag           (fill_tag),
    .i_fill_dirty         (fill_dirty),
    .i_set_dirty          (sb_set_dirty),
    .i_dirty_index        (sb_req_index),
    .i_dirty_way_vec      ({sb_way, ~sb_way}),
    .o_victim_tag         (victim_tag)
  );

  store_buffer u_store_buffer (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_load      (sb_load),
    .i_way_vec   (sb_way_vec),
    .i_index     (sb_index),
    .i_wsel      (sb_wsel),
    .i_strb      (sb_strb),
    .i_data      (sb_data),
    .o_req       (sb_req),
    .o_way       (sb_way),
    .o_index     (sb_req_index),
    .o_wsel      (sb_req_wsel),
    .o_strb      (sb_req_strb),
    .o_data      (sb_req_data),
    .o_set_dirty (sb_set_dirty)
  );

  data_port_arbiter u_arbiter (
    .i_sb_req    (sb_req),
    .i_sb_way    (sb_way),
    .i_sb_index  (sb_req_index),
    .i_sb_wsel   (sb_req_wsel),
    .i_sb_strb   (sb_req_strb),
    .i_sb_data   (sb_req_data),
    .i_mc_rd_en  (mc_rd_en),
    .i_mc_wr_en  (mc_wr_en),
    .i_mc_index  (lookup_index),
    .i_mc_way    (mc_way),
    .i_mc_wsel   (mc_wsel),
    .i_mc_strb   (mc_strb),
    .i_mc_data   (mc_data),
    .o_mc_gnt    (mc_gnt),
    .o_en        (arr_en),
    .o_we        (arr_we),
    .o_index     (arr_index),
    .o_bit_mask  (arr_mask),
    .o_wdata     (arr_wdata)
  );

  data_array u_data_array (
    .i_clk      (i_clk),
    .i_en       (arr_en),
    .i_we       (arr_we),
    .i_index    (arr_index),
    .i_bit_mask (arr_mask),
    .i_wdata    (arr_wdata),
    .o_rdata    (line_rd)
  );

endmodule

`default_nettype wire

// File: logic/cache_main_ctrl.sv
// main cache controller: request register, lookup, victim write-back and line refill
`timescale 1ns/1ns
`default_nettype none

module cache_main_ctrl
  import cache_geom_pkg::*;
  import cache_ctrl_pkg::*;
(
  input  wire                i_clk,
  input  wire                i_rst,
  // pipeline
  input  wire                i_valid,
  input  wire op_t           i_op,
  input  wire tag_t          i_tag,
  input  wire index_t        i_index,
  input  wire offset_t       i_offset,
  input  wire strb_t         i_wstrb,
  input  wire word_t         i_wdata,
  output logic               o_addr_ok,
  output logic               o_data_ok,
  output word_t              o_rdata,
  // bus
  output logic               o_rd_req,
  output logic [ADDR_W-1:0]  o_rd_addr,
  input  wire                i_rd_rdy,
  input  wire                i_ret_valid,
  input  wire                i_ret_last,
  input  wire word_t         i_ret_data,
  output logic               o_wr_req,
  output logic [ADDR_W-1:0]  o_wr_addr,
  output line_t              o_wr_data,
  input  wire                i_wr_rdy,
  // tag store
  output index_t             o_lookup_index,
  output logic               o_fill_en,
  output way_t               o_fill_way,
  output tag_t               o_fill_tag,
  output logic               o_fill_dirty,
  input  wire way_vec_t      i_hit_vec,
  input  wire                i_victim_dirty,
  input  wire tag_t          i_victim_tag,
  // store buffer load
  output logic               o_sb_load,
  output way_vec_t           o_sb_way_vec,
  output index_t             o_sb_index,
  output word_sel_t          o_sb_wsel,
  output strb_t              o_sb_strb,
  output word_t              o_sb_data,
  // data array access
  output logic               o_mc_rd_en,
  output logic               o_mc_wr_en,
  output way_t               o_mc_way,
  output word_sel_t          o_mc_wsel,
  output strb_t              o_mc_strb,
  output word_t              o_mc_data,
  input  wire                i_mc_gnt,
  input  wire line_t         i_line_rd [WAYS]
);

  main_state_t state_q;
  main_state_t state_d;
  op_t         req_op;
  tag_t        req_tag;
  index_t      req_index;
  word_sel_t   req_wsel;
  strb_t       req_wstrb;
  word_t       req_wdata;
  word_sel_t   beat_cnt;     // refill beats seen so far
  way_t        victim_q;     // flips after every refill
  logic        hit;
  logic        accept;
  logic        ret_beat;
  logic        req_beat;
  word_t       fill_word;

  assign hit       = |i_hit_vec;
  assign o_addr_ok = i_mc_gnt && (state_q == ST_IDLE ||
                     (state_q == ST_LOOKUP && hit && req_op == OP_READ));
  assign accept    = i_valid && o_addr_ok;
  assign ret_beat  = state_q == ST_REFILL && i_ret_valid;
  assign req_beat  = beat_cnt == req_wsel;

  // --------------------------------------------------
  // request register and state machine
  always_ff @(posedge i_clk) begin
    if (accept) begin
      req_op    <= i_op;
      req_tag   <= i_tag;
      req_index <= i_index;
      req_wsel  <= i_offset[OFFSET_W-1 -: WSEL_W];   // byte bits dropped
      req_wstrb <= i_wstrb;
      req_wdata <= i_wdata;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:    if (accept) state_d = ST_LOOKUP;
      ST_LOOKUP: begin
        if (!hit) begin
          state_d = ST_MISS;
        end else if (!accept) begin
          state_d = ST_IDLE;
        end
      end
      ST_MISS:    if (!i_victim_dirty || i_wr_rdy) state_d = ST_REPLACE;
      ST_REPLACE: if (i_rd_rdy) state_d = ST_REFILL;
      ST_REFILL:  if (ret_beat && i_ret_last) state_d = ST_IDLE;
      default:    state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q  <= ST_IDLE;
      beat_cnt <= '0;
      victim_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q != ST_REFILL) begin
        beat_cnt <= '0;
      end else if (i_ret_valid) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
      if (o_fill_en) begin
        victim_q <= ~victim_q;
      end
    end
  end

  // --------------------------------------------------
  // pipeline results
  assign o_data_ok = (state_q == ST_LOOKUP && (hit || req_op == OP_WRITE)) ||
                     (ret_beat && req_beat && req_op == OP_READ);
  assign o_rdata   = (state_q == ST_LOOKUP)
                   ? i_line_rd[i_hit_vec[1]][req_wsel*WORD_W +: WORD_W]
                   : i_ret_data;

  // --------------------------------------------------
  // bus requests
  assign o_rd_req  = state_q == ST_REPLACE;
  assign o_rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};
  assign o_wr_req  = state_q == ST_MISS && i_victim_dirty && i_wr_rdy;
  assign o_wr_addr = {i_victim_tag, req_index, {OFFSET_W{1'b0}}};
  assign o_wr_data = i_line_rd[victim_q];    // held since the lookup read

  // tag store
  assign o_lookup_index = accept ? i_index : req_index;
  assign o_fill_en      = ret_beat && i_ret_last;
  assign o_fill_way     = victim_q;
  assign o_fill_tag     = req_tag;
  assign o_fill_dirty   = req_op == OP_WRITE;   // store miss lands dirty

  // store hit hand-off
  assign o_sb_load    = state_q == ST_LOOKUP && hit && req_op == OP_WRITE;
  assign o_sb_way_vec = i_hit_vec;
  assign o_sb_index   = req_index;
  assign o_sb_wsel    = req_wsel;
  assign o_sb_strb    = req_wstrb;
  assign o_sb_data    = req_wdata;

  // refill beat, store bytes merged into the requested word
  always_comb begin
    fill_word = i_ret_data;
    if (req_op == OP_WRITE && req_beat) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (req_wstrb[b]) begin
          fill_word[b*8 +: 8] = req_wdata[b*8 +: 8];
        end
      end
    end
  end

  assign o_mc_rd_en = accept;
  assign o_mc_wr_en = ret_beat;
  assign o_mc_way   = victim_q;
  assign o_mc_wsel  = beat_cnt;
  assign o_mc_strb  = '1;        // whole word per beat
  assign o_mc_data  = fill_word;

endmodule

`default_nettype wire

// File: logic/tag_store.sv
// per-set tags with valid and dirty bits, registered read and two-way hit compare
`timescale 1ns/1ns
`default_nettype none

module tag_store
  import cache_geom_pkg::*;
(
  input  wire            i_clk,
  input  wire            i_rst,
  input  wire index_t    i_index,
  input  wire tag_t      i_tag,
  input  wire way_t      i_victim,
  output way_vec_t       o_hit_vec,
  output logic           o_victim_valid_dirty,
  input  wire            i_fill_en,
  input  wire way_t      i_fill_way,
  input  wire tag_t      i_fill_tag,
  input  wire            i_fill_dirty,
  input  wire            i_set_dirty,
  input  wire index_t    i_dirty_index,
  input  wire way_vec_t  i_dirty_way_vec,
  output tag_t           o_victim_tag
);

  tag_t     tag_mem [SETS][WAYS];
  way_vec_t valid_q [SETS];
  way_vec_t dirty_q [SETS];
  tag_t     tag_rd [WAYS];    // set read in the previous cycle
  way_vec_t valid_rd;
  way_vec_t dirty_rd;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int s = 0; s < SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
      valid_rd <= '0;
      dirty_rd <= '0;
    end else begin
      valid_rd <= valid_q[i_index];
      dirty_rd <= dirty_q[i_index];
      if (i_fill_en) begin
        valid_q[i_index][i_fill_way] <= 1'b1;
        dirty_q[i_index][i_fill_way] <= i_fill_dirty;
      end
      if (i_set_dirty) begin
        dirty_q[i_dirty_index] <= dirty_q[i_dirty_index] | i_dirty_way_vec;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fill_en) begin
      tag_mem[i_index][i_fill_way] <= i_fill_tag;
    end
    for (int w = 0; w < WAYS; w++) begin
      tag_rd[w] <= tag_mem[i_index][w];
    end
  end

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      o_hit_vec[w] = valid_rd[w] && (tag_rd[w] == i_tag);
    end
  end

  // victim info for write-back
  assign o_victim_valid_dirty = valid_rd[i_victim] && dirty_rd[i_victim];
  assign o_victim_tag         = tag_rd[i_victim];

endmodule

`default_nettype wire

// File: logic/store_buffer.sv
// one-entry write buffer, retires a store hit into the data array the cycle after lookup
`timescale 1ns/1ns
`default_nettype none

module store_buffer
  import cache_geom_pkg::*;
  import cache_ctrl_pkg::*;
(
  input  wire             i_clk,
  input  wire             i_rst,
  input  wire             i_load,
  input  wire way_vec_t   i_way_vec,
  input  wire index_t     i_index,
  input  wire word_sel_t  i_wsel,
  input  wire strb_t      i_strb,
  input  wire word_t      i_data,
  output logic            o_req,
  output way_t            o_way,
  output index_t          o_index,
  output word_sel_t       o_wsel,
  output strb_t           o_strb,
  output word_t           o_data,
  output logic            o_set_dirty
);

  sbuf_state_t state_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= SB_IDLE;
    end else begin
      case (state_q)
        SB_IDLE:  state_q <= i_load ? SB_WRITE : SB_IDLE;
        SB_WRITE: state_q <= SB_IDLE;   // single write cycle
        default:  state_q <= SB_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      o_way   <= i_way_vec[1];    // one-hot to way number
      o_index <= i_index;
      o_wsel  <= i_wsel;
      o_strb  <= i_strb;
      o_data  <= i_data;
    end
  end

  assign o_req       = state_q == SB_WRITE;
  assign o_set_dirty = state_q == SB_WRITE;

endmodule

`default_nettype wire

// File: logic/data_port_arbiter.sv
// data array port arbiter, store buffer over main controller, with word to line placement
`timescale 1ns/1ns
`default_nettype none

module data_port_arbiter
  import cache_geom_pkg::*;
(
  input  wire             i_sb_req,
  input  wire way_t       i_sb_way,
  input  wire index_t     i_sb_index,
  input  wire word_sel_t  i_sb_wsel,
  input  wire strb_t      i_sb_strb,
  input  wire word_t      i_sb_data,
  input  wire             i_mc_rd_en,
  input  wire             i_mc_wr_en,
  input  wire index_t     i_mc_index,
  input  wire way_t       i_mc_way,
  input  wire word_sel_t  i_mc_wsel,
  input  wire strb_t      i_mc_strb,
  input  wire word_t      i_mc_data,
  output logic            o_mc_gnt,
  output logic            o_en,
  output way_vec_t        o_we,
  output index_t          o_index,
  output line_t           o_bit_mask,
  output line_t           o_wdata
);

  word_sel_t wsel;
  strb_t     strb;
  word_t     wdata;
  word_t     word_mask;

  assign o_mc_gnt = ~i_sb_req;
  assign o_en     = i_sb_req || i_mc_rd_en || i_mc_wr_en;

  always_comb begin
    if (i_sb_req) begin
      o_we    = way_vec_t'(1) << i_sb_way;
      o_index = i_sb_index;
      wsel    = i_sb_wsel;
      strb    = i_sb_strb;
      wdata   = i_sb_data;
    end else begin
      o_we    = i_mc_wr_en ? way_vec_t'(1) << i_mc_way : '0;
      o_index = i_mc_index;
      wsel    = i_mc_wsel;
      strb    = i_mc_strb;
      wdata   = i_mc_data;
    end
    for (int b = 0; b < STRB_W; b++) begin
      word_mask[b*8 +: 8] = {8{strb[b]}};   // byte enable to bit enable
    end
    o_bit_mask = line_t'(word_mask) << (wsel * WORD_W);
    o_wdata    = line_t'(wdata) << (wsel * WORD_W);
  end

endmodule

`default_nettype wire

// File: logic/data_array.sv
// two-way line storage, bit-masked writes and a registered read that holds between reads
`timescale 1ns/1ns
`default_nettype none

module data_array
  import cache_geom_pkg::*;
(
  input  wire            i_clk,
  input  wire            i_en,
  input  wire way_vec_t  i_we,
  input  wire index_t    i_index,
  input  wire line_t     i_bit_mask,
  input  wire line_t     i_wdata,
  output line_t          o_rdata [WAYS]
);

  line_t mem [SETS][WAYS];

  always_ff @(posedge i_clk) begin
    for (int w = 0; w < WAYS; w++) begin
      if (i_en && i_we[w]) begin
        mem[i_index][w] <= (mem[i_index][w] & ~i_bit_mask) | (i_wdata & i_bit_mask);
      end
      if (i_en && i_we == '0) begin
        o_rdata[w] <= mem[i_index][w];   // read only, output holds otherwise
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/cache_ctrl_pkg.sv
// state and operation encodings for the cache controllers
`default_nettype none

package cache_ctrl_pkg;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_MISS,       // victim write-back
    ST_REPLACE,    // line read request
    ST_REFILL
  } main_state_t;

  typedef enum logic {
    SB_IDLE,
    SB_WRITE
  } sbuf_state_t;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } op_t;

endpackage

`default_nettype wire

// File: logic/cache_geom_pkg.sv
// cache geometry and address field types, imported by every cache module
`default_nettype none

package cache_geom_pkg;

  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 64;
  localparam int STRB_W         = WORD_W / 8;      // one enable per byte
  localparam int LINE_BYTES     = 32;
  localparam int LINE_W         = LINE_BYTES * 8;
  localparam int WAYS           = 2;
  localparam int SETS           = 64;
  localparam int WORDS_PER_LINE = LINE_W / WORD_W;
  localparam int OFFSET_W       = $clog2(LINE_BYTES);
  localparam int INDEX_W        = $clog2(SETS);
  localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WSEL_W         = $clog2(WORDS_PER_LINE);

  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [WSEL_W-1:0]   word_sel_t;      // word number inside a line
  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [STRB_W-1:0]   strb_t;
  typedef logic [LINE_W-1:0]   line_t;
  typedef logic                way_t;
  typedef logic [WAYS-1:0]     way_vec_t;       // one-hot per way

endpackage

`default_nettype wire
